//--- compile.f
+incdir+include
src/tank_pkg.sv
src/tank_base_move.sv
src/turret_ctrl.sv
src/bullet_step.sv
src/bullet_bank.sv
src/tank_game_top.sv
dv/tank_game_tb.sv

//--- dv/tank_game_tb.sv
//----------------------------------------
// testbench for the tank game engine with
// reference model, assertions and timeout
//----------------------------------------
`include "tank_config.svh"

module tank_game_tb import tank_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	// frame counts per stimulus phase
	localparam int EDGE_FRAMES   = 1520;
	localparam int SWEEP_FRAMES  = 140;
	localparam int MOVE_FRAMES   = 1200; // upper bound for positioning
	localparam int BURST_FRAMES  = 100;
	localparam int DRAIN_FRAMES  = 260;
	localparam int RANDOM_FRAMES = 3000;
	localparam int TEST_FRAMES   = 2 + EDGE_FRAMES + SWEEP_FRAMES + MOVE_FRAMES
		+ BURST_FRAMES + DRAIN_FRAMES + RANDOM_FRAMES + 10;
	localparam int TIMEOUT_FRAMES = 2 * TEST_FRAMES;

	logic clk; // drives the Reset port
	logic rst; // drives the frame_clk port
	key_word_t keys;
	tank_state_t [`TANK_NUM-1:0] tanks;
	bullet_t [`TANK_NUM-1:0][`SLOT_NUM-1:0] bullets;
	logic [`TANK_NUM-1:0] hit;

	// reference model state
	int         m_x [`TANK_NUM];
	int         m_y [`TANK_NUM];
	logic [2:0] m_dir [`TANK_NUM];
	logic [6:0] m_ang [`TANK_NUM];
	logic       m_latch [`TANK_NUM];
	int         m_phase;
	bullet_t    m_bul [`TANK_NUM][`SLOT_NUM];
	logic [`TANK_NUM-1:0] m_hit;

	int err_count = 0;
	int cycles = 0;
	int hits_seen = 0;
	int spawns = 0;
	int shots_lost = 0;

	// per-direction steps, index is the direction code
	int dir_dx [8] = '{0, -1, -1, -1, 0, 1, 1, 1};
	int dir_dy [8] = '{-1, -1, 0, 1, 1, 1, 0, -1};

	tank_game_top u_tank_game_top (
		.Reset     (clk),
		.frame_clk (rst),
		.keys      (keys),
		.tanks     (tanks),
		.bullets   (bullets),
		.hit       (hit)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//----------------------------------------
	// reference model
	//----------------------------------------
	function automatic logic in_box(bullet_t bl, int tx, int ty);
		return bl.valid && int'(bl.x) >= tx && int'(bl.x) < tx + `TANK_SIZE
			&& int'(bl.y) >= ty && int'(bl.y) < ty + `TANK_SIZE;
	endfunction

	function automatic bullet_t next_bullet(bullet_t bl);
		bullet_t nb;
		nb = '0;
		if (!bl.valid) return nb;
		for (int t = 0; t < `TANK_NUM; t++) begin
			if (in_box(bl, m_x[t], m_y[t])) return nb; // absorbed by a tank
		end
		if (int'(bl.x) > `SCREEN_X_MAX || int'(bl.y) > `SCREEN_Y_MAX) return nb;
		nb.valid = 1'b1;
		nb.dir = bl.dir;
		nb.x = 10'(int'(bl.x) + dir_dx[bl.dir]);
		nb.y = 10'(int'(bl.y) + dir_dy[bl.dir]);
		return nb;
	endfunction

	always @(posedge clk or posedge rst) begin : model_update
		logic [`TANK_NUM-1:0] go;
		int free;
		if (rst) begin
			m_x = '{`TANK0_X0, `TANK1_X0};
			m_y = '{`TANK0_Y0, `TANK1_Y0};
			m_phase = 0;
			for (int t = 0; t < `TANK_NUM; t++) begin
				m_dir[t] = '0;
				m_ang[t] = '0;
				m_latch[t] = 1'b0;
				for (int s = 0; s < `SLOT_NUM; s++) m_bul[t][s] = '0;
			end
			m_hit = '0;
		end else begin
			// bullets first, they see the old tank positions
			for (int b = 0; b < `TANK_NUM; b++) begin
				go[b] = m_latch[b] && (m_phase == 0);
				free = -1;
				for (int s = 0; s < `SLOT_NUM; s++) begin
					if (go[b] && !m_bul[b][s].valid && free < 0) free = s;
				end
				if (go[b] && free < 0) shots_lost++;
				for (int s = 0; s < `SLOT_NUM; s++) begin
					if (s == free) begin
						m_bul[b][s].valid = 1'b1;
						m_bul[b][s].dir = m_ang[b][6:4];
						m_bul[b][s].x = 10'(m_x[b] + `TANK_SIZE / 2);
						m_bul[b][s].y = 10'(m_y[b] - 1);
						spawns++;
					end else begin
						m_bul[b][s] = next_bullet(m_bul[b][s]);
					end
				end
			end
			for (int t = 0; t < `TANK_NUM; t++) begin
				case (keys[t].base)
					`KEY_LEFT: begin
						if (m_x[t] > 0) m_x[t]--;
						m_dir[t] = 3'd2;
					end
					`KEY_DOWN: begin
						if (m_y[t] + `TANK_SIZE >= `SCREEN_Y_MAX) m_y[t] = `SCREEN_Y_MAX - `TANK_SIZE;
						else m_y[t]++;
						m_dir[t] = 3'd4;
					end
					`KEY_UP: begin
						if (m_y[t] > 0) m_y[t]--;
						m_dir[t] = 3'd0;
					end
					`KEY_RIGHT: begin
						if (m_x[t] + `TANK_SIZE >= `SCREEN_X_MAX) m_x[t] = `SCREEN_X_MAX - `TANK_SIZE;
						else m_x[t]++;
						m_dir[t] = 3'd6;
					end
					default: ;
				endcase
				if (keys[t].turret == `KEY_ROT_UP) m_ang[t] = m_ang[t] + 7'd1;
				if (keys[t].turret == `KEY_ROT_DOWN) m_ang[t] = m_ang[t] - 7'd1;
				if (go[t]) m_latch[t] = 1'b0;
				else if (keys[t].turret == `KEY_FIRE) m_latch[t] = 1'b1;
			end
			m_phase = (m_phase + 1) % `FIRE_PERIOD;
			m_hit = '0;
			for (int b = 0; b < `TANK_NUM; b++) begin
				for (int s = 0; s < `SLOT_NUM; s++) begin
					for (int t = 0; t < `TANK_NUM; t++) begin
						if (in_box(m_bul[b][s], m_x[t], m_y[t])) m_hit[t] = 1'b1;
					end
				end
			end
			if (m_hit != '0) hits_seen++;
		end
	end

	//----------------------------------------
	// checks
	//----------------------------------------
	for (genvar t = 0; t < `TANK_NUM; t++) begin : g_tank_chk
		a_x: assert property (@(posedge clk) disable iff (rst) tanks[t].x == m_x[t])
			else begin
				err_count++;
				$display("ERR %0t tanks[%0d].x exp %0d got %0d", $time, t,
					$sampled(m_x[t]), $sampled(tanks[t].x));
			end
		a_y: assert property (@(posedge clk) disable iff (rst) tanks[t].y == m_y[t])
			else begin
				err_count++;
				$display("ERR %0t tanks[%0d].y exp %0d got %0d", $time, t,
					$sampled(m_y[t]), $sampled(tanks[t].y));
			end
		a_dir: assert property (@(posedge clk) disable iff (rst) tanks[t].base_dir == m_dir[t])
			else begin
				err_count++;
				$display("ERR %0t tanks[%0d].base_dir exp %0d got %0d", $time, t,
					$sampled(m_dir[t]), $sampled(tanks[t].base_dir));
			end
		a_aim: assert property (@(posedge clk) disable iff (rst) tanks[t].aim == m_ang[t][6:4])
			else begin
				err_count++;
				$display("ERR %0t tanks[%0d].aim exp %0d got %0d", $time, t,
					$sampled(m_ang[t][6:4]), $sampled(tanks[t].aim));
			end
		for (genvar s = 0; s < `SLOT_NUM; s++) begin : g_slot_chk
			a_bul: assert property (@(posedge clk) disable iff (rst)
				bullets[t][s] == m_bul[t][s])
				else begin
					err_count++;
					$display("ERR %0t bullets[%0d][%0d] exp %h got %h", $time, t, s,
						$sampled(m_bul[t][s]), $sampled(bullets[t][s]));
				end
		end
	end

	a_hit: assert property (@(posedge clk) disable iff (rst) hit == m_hit)
		else begin
			err_count++;
			$display("ERR %0t hit exp %b got %b", $time, $sampled(m_hit), $sampled(hit));
		end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_FRAMES) begin
			$display("timeout, stimulus still running after %0d frames", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	//----------------------------------------
	// stimulus helpers
	//----------------------------------------
	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] v;
		v = s;
		v ^= v << 13;
		v ^= v >> 17;
		v ^= v << 5;
		return v;
	endfunction

	function automatic key_word_t make_keys(input logic [7:0] b0, t0, b1, t1);
		key_word_t k;
		k[0].base = b0;
		k[0].turret = t0;
		k[1].base = b1;
		k[1].turret = t1;
		return k;
	endfunction

	task automatic next_frame();
		@(posedge clk);
		#5;
	endtask

	task automatic hold_keys(input key_word_t k, input int n);
		keys = k;
		repeat (n) next_frame();
	endtask

	// steps one tank toward a target, model tracks the position
	task automatic move_tank(input int t, input int tx, input int ty);
		key_word_t k;
		while (m_x[t] != tx) begin
			k = '0;
			k[t].base = (m_x[t] > tx) ? `KEY_LEFT : `KEY_RIGHT;
			hold_keys(k, 1);
		end
		while (m_y[t] != ty) begin
			k = '0;
			k[t].base = (m_y[t] > ty) ? `KEY_UP : `KEY_DOWN;
			hold_keys(k, 1);
		end
	endtask

	task automatic set_angle(input int t, input logic [6:0] target);
		key_word_t k;
		k = '0;
		k[t].turret = `KEY_ROT_UP;
		while (m_ang[t] != target) hold_keys(k, 1);
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		rnd = 32'd25343;
		keys = '0;
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#5 rst = 1'b0;

		// every screen edge for both tanks
		hold_keys(make_keys(`KEY_LEFT, 0, `KEY_RIGHT, 0), 220);
		hold_keys(make_keys(`KEY_UP, 0, `KEY_DOWN, 0), 220);
		hold_keys(make_keys(`KEY_RIGHT, 0, `KEY_LEFT, 0), 620);
		hold_keys(make_keys(`KEY_DOWN, 0, `KEY_UP, 0), 460);

		// turret sweeps past the wrap point
		hold_keys(make_keys(0, `KEY_ROT_UP, 0, `KEY_ROT_DOWN), SWEEP_FRAMES);

		// tank 1 straight above tank 0, both aiming up
		move_tank(0, 300, 400);
		move_tank(1, 300, 200);
		set_angle(0, 7'd0);
		set_angle(1, 7'd0);
		hold_keys(make_keys(0, `KEY_FIRE, 0, `KEY_FIRE), BURST_FRAMES);
		hold_keys('0, DRAIN_FRAMES); // bullets reach tank 1 or leave the top

		for (int i = 0; i < RANDOM_FRAMES; i++) begin
			rnd = xorshift32(rnd);
			keys = make_keys(8'(rnd[7:0] % 6), 8'(rnd[15:8] % 5),
				8'(rnd[23:16] % 6), 8'(rnd[31:24] % 5));
			next_frame();
		end
		hold_keys('0, 4);

		if (hits_seen == 0) begin
			err_count++;
			$display("no bullet ever reached a tank box");
		end
		if (shots_lost == 0) begin
			err_count++;
			$display("no shot was ever lost to a full bullet bank");
		end
		$display("run done with %0d errors, %0d spawns, %0d hit frames, %0d lost shots",
			err_count, spawns, hits_seen, shots_lost);
		if (err_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

//--- include/tank_config.svh
//----------------------------------------
// screen limits, tank and bullet bank sizes,
// fire period, reset positions and key codes
//----------------------------------------
`ifndef TANK_CONFIG_SVH
`define TANK_CONFIG_SVH

`define SCREEN_X_MAX 639 // last visible pixel
`define SCREEN_Y_MAX 479
`define TANK_SIZE    32  // square tank box side

`define TANK_NUM     2
`define SLOT_NUM     4   // bullets per tank
`define FIRE_PERIOD  16  // frames, power of two

`define TANK0_X0     200
`define TANK0_Y0     200
`define TANK1_X0     400
`define TANK1_Y0     400

// base keys
`define KEY_LEFT     8'd1
`define KEY_DOWN     8'd2
`define KEY_UP       8'd3
`define KEY_RIGHT    8'd4

// turret keys
`define KEY_ROT_UP   8'd1
`define KEY_ROT_DOWN 8'd2
`define KEY_FIRE     8'd3

`endif

//--- src/bullet_bank.sv
//----------------------------------------
// one tank's bullet slots, spawn into the
// lowest free slot and per-slot stepping
//----------------------------------------
`include "tank_config.svh"

module bullet_bank import tank_pkg::*; (
	input  logic                         Reset,     // frame clock
	input  logic                         frame_clk, // async reset
	input  logic                         fire_go,
	input  tank_state_t                  shooter,
	input  tank_state_t [`TANK_NUM-1:0]  tanks,
	output bullet_t [`SLOT_NUM-1:0]      slots,
	output logic [`TANK_NUM-1:0]         hit
);

	bullet_t [`SLOT_NUM-1:0]                  slot_nxt;
	logic [`SLOT_NUM-1:0][`TANK_NUM-1:0]      slot_hit;
	logic [`SLOT_NUM-1:0]                     spawn_sel; // one-hot
	logic                                     taken;
	bullet_t                                  spawn;

	//----------------------------------------
	// per-slot next state
	//----------------------------------------
	for (genvar g = 0; g < `SLOT_NUM; g++) begin : g_slot
		bullet_step u_bullet_step (
			.cur   (slots[g]),
			.tanks (tanks),
			.nxt   (slot_nxt[g]),
			.hit   (slot_hit[g])
		);
	end

	always_comb begin
		hit = '0;
		for (int i = 0; i < `SLOT_NUM; i++) begin
			hit = hit | slot_hit[i];
		end
	end

	//----------------------------------------
	// lowest free slot, nothing when full
	//----------------------------------------
	always_comb begin
		taken = 1'b0;
		spawn_sel = '0;
		for (int i = 0; i < `SLOT_NUM; i++) begin
			if (fire_go && !slots[i].valid && !taken) begin
				spawn_sel[i] = 1'b1;
				taken = 1'b1;
			end
		end
	end

	// muzzle sits centred just above the box
	always_comb begin
		spawn.valid = 1'b1;
		spawn.dir = shooter.aim;
		spawn.x = shooter.x + 10'(`TANK_SIZE / 2);
		spawn.y = shooter.y - 10'd1;
	end

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			slots <= '0;
		end else begin
			for (int i = 0; i < `SLOT_NUM; i++) begin
				slots[i] <= spawn_sel[i] ? spawn : slot_nxt[i];
			end
		end
	end

endmodule

//--- src/bullet_step.sv
//----------------------------------------
// next state of one bullet slot with
// motion, screen exit and tank hit test
//----------------------------------------
`include "tank_config.svh"

module bullet_step import tank_pkg::*; (
	input  bullet_t                      cur,
	input  tank_state_t [`TANK_NUM-1:0]  tanks,
	output bullet_t                      nxt,
	output logic [`TANK_NUM-1:0]         hit
);

	logic signed [1:0] dx;
	logic signed [1:0] dy;
	logic              off_screen;

	// direction decode, -1/0/+1 per axis
	always_comb begin
		case (cur.dir)
			3'd0: begin dx = 2'sd0;  dy = -2'sd1; end // up
			3'd1: begin dx = -2'sd1; dy = -2'sd1; end
			3'd2: begin dx = -2'sd1; dy = 2'sd0;  end // left
			3'd3: begin dx = -2'sd1; dy = 2'sd1;  end
			3'd4: begin dx = 2'sd0;  dy = 2'sd1;  end // down
			3'd5: begin dx = 2'sd1;  dy = 2'sd1;  end
			3'd6: begin dx = 2'sd1;  dy = 2'sd0;  end // right
			default: begin
				dx = 2'sd1;
				dy = -2'sd1;
			end
		endcase
	end

	// box overlap per tank, 11 bits so the far edge does not wrap
	always_comb begin
		for (int k = 0; k < `TANK_NUM; k++) begin
			hit[k] = cur.valid
				&& (cur.x >= tanks[k].x)
				&& ({1'b0, cur.x} < {1'b0, tanks[k].x} + 11'(`TANK_SIZE))
				&& (cur.y >= tanks[k].y)
				&& ({1'b0, cur.y} < {1'b0, tanks[k].y} + 11'(`TANK_SIZE));
		end
	end

	assign off_screen = (cur.x > 10'(`SCREEN_X_MAX)) || (cur.y > 10'(`SCREEN_Y_MAX));

	always_comb begin
		if (!cur.valid || (hit != '0) || off_screen) begin
			nxt = '0; // slot freed
		end else begin
			nxt.valid = 1'b1;
			nxt.dir = cur.dir;
			nxt.x = cur.x + {{8{dx[1]}}, dx}; // wraps in 10 bits
			nxt.y = cur.y + {{8{dy[1]}}, dy};
		end
	end

endmodule

//--- src/tank_base_move.sv
//----------------------------------------
// tank base position and heading registers
//----------------------------------------
`include "tank_config.svh"

module tank_base_move import tank_pkg::*; (
	input  logic       Reset,     // frame clock
	input  logic       frame_clk, // async reset
	input  logic [7:0] key,
	input  coord_t     init_x,
	input  coord_t     init_y,
	output coord_t     x,
	output coord_t     y,
	output dir_t       base_dir
);

	coord_t x_nxt;
	coord_t y_nxt;
	dir_t   dir_nxt;

	// clamped one-pixel step
	always_comb begin
		x_nxt = x;
		y_nxt = y;
		dir_nxt = base_dir;
		case (key)
			`KEY_LEFT: begin
				if (x != '0) begin
					x_nxt = x - 10'd1;
				end
				dir_nxt = 3'd2;
			end
			`KEY_DOWN: begin
				if ({1'b0, y} + 11'(`TANK_SIZE) >= 11'(`SCREEN_Y_MAX)) begin
					y_nxt = 10'(`SCREEN_Y_MAX - `TANK_SIZE);
				end else begin
					y_nxt = y + 10'd1;
				end
				dir_nxt = 3'd4;
			end
			`KEY_UP: begin
				if (y != '0) begin
					y_nxt = y - 10'd1;
				end
				dir_nxt = 3'd0;
			end
			`KEY_RIGHT: begin
				if ({1'b0, x} + 11'(`TANK_SIZE) >= 11'(`SCREEN_X_MAX)) begin
					x_nxt = 10'(`SCREEN_X_MAX - `TANK_SIZE);
				end else begin
					x_nxt = x + 10'd1;
				end
				dir_nxt = 3'd6;
			end
			default: ; // hold
		endcase
	end

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			x <= init_x;
			y <= init_y;
			base_dir <= '0;
		end else begin
			x <= x_nxt;
			y <= y_nxt;
			base_dir <= dir_nxt;
		end
	end

endmodule

//--- src/tank_game_top.sv
//----------------------------------------
// two tanks with turrets and bullet banks
//----------------------------------------
`include "tank_config.svh"

module tank_game_top import tank_pkg::*; (
	input  logic                                     Reset,     // frame clock
	input  logic                                     frame_clk, // async reset
	input  key_word_t                                keys,
	output tank_state_t [`TANK_NUM-1:0]              tanks,
	output bullet_t [`TANK_NUM-1:0][`SLOT_NUM-1:0]   bullets,
	output logic [`TANK_NUM-1:0]                     hit
);

	coord_t [`TANK_NUM-1:0]                 init_x;
	coord_t [`TANK_NUM-1:0]                 init_y;
	coord_t [`TANK_NUM-1:0]                 pos_x;
	coord_t [`TANK_NUM-1:0]                 pos_y;
	dir_t [`TANK_NUM-1:0]                   base_dir;
	dir_t [`TANK_NUM-1:0]                   aim;
	logic [`TANK_NUM-1:0]                   fire_go;
	logic [`TANK_NUM-1:0][`TANK_NUM-1:0]    bank_hit; // [bank][tank]

	// reset positions
	assign init_x[0] = 10'(`TANK0_X0);
	assign init_y[0] = 10'(`TANK0_Y0);
	assign init_x[1] = 10'(`TANK1_X0);
	assign init_y[1] = 10'(`TANK1_Y0);

	//----------------------------------------
	// per-tank blocks
	//----------------------------------------
	for (genvar g = 0; g < `TANK_NUM; g++) begin : g_tank
		tank_base_move u_tank_base_move (
			.Reset     (Reset),
			.frame_clk (frame_clk),
			.key       (keys[g].base),
			.init_x    (init_x[g]),
			.init_y    (init_y[g]),
			.x         (pos_x[g]),
			.y         (pos_y[g]),
			.base_dir  (base_dir[g])
		);

		turret_ctrl u_turret_ctrl (
			.Reset     (Reset),
			.frame_clk (frame_clk),
			.key       (keys[g].turret),
			.aim       (aim[g]),
			.fire_go   (fire_go[g])
		);

		bullet_bank u_bullet_bank (
			.Reset     (Reset),
			.frame_clk (frame_clk),
			.fire_go   (fire_go[g]),
			.shooter   (tanks[g]),
			.tanks     (tanks),
			.slots     (bullets[g]),
			.hit       (bank_hit[g])
		);
	end

	always_comb begin
		for (int t = 0; t < `TANK_NUM; t++) begin
			tanks[t].x = pos_x[t];
			tanks[t].y = pos_y[t];
			tanks[t].base_dir = base_dir[t];
			tanks[t].aim = aim[t];
		end
	end

	// any bank can hit any tank, own tank included
	always_comb begin
		hit = '0;
		for (int b = 0; b < `TANK_NUM; b++) begin
			hit = hit | bank_hit[b];
		end
	end

endmodule

//--- src/tank_pkg.sv
//----------------------------------------
// shared types for the tank game engine
//----------------------------------------
`include "tank_config.svh"

package tank_pkg;

	typedef logic [9:0] coord_t; // pixel coordinate

	// 0 up, 1 up-left, 2 left, 3 down-left, 4 down, 5 down-right, 6 right, 7 up-right
	typedef logic [2:0] dir_t;

	typedef logic [6:0] angle_t; // top 3 bits give aim

	// per-tank key codes, base in the upper byte
	typedef struct packed {
		logic [7:0] base;
		logic [7:0] turret;
	} key_pair_t;

	// tank 0 sits in the top half of the word
	typedef key_pair_t [0:`TANK_NUM-1] key_word_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		dir_t   base_dir;
		dir_t   aim;
	} tank_state_t;

	typedef struct packed {
		logic   valid;
		dir_t   dir;
		coord_t x;
		coord_t y;
	} bullet_t;

endpackage

//--- src/turret_ctrl.sv
//----------------------------------------
// turret angle, fire latch and fire phase
//----------------------------------------
`include "tank_config.svh"

module turret_ctrl import tank_pkg::*; (
	input  logic       Reset,     // frame clock
	input  logic       frame_clk, // async reset
	input  logic [7:0] key,
	output dir_t       aim,
	output logic       fire_go
);

	angle_t angle;
	logic   fire_latch;
	logic [$clog2(`FIRE_PERIOD)-1:0] phase; // wraps on its own

	assign aim = angle[6:4];

	// one grant per period, only on phase 0
	assign fire_go = fire_latch && (phase == '0);

	//----------------------------------------
	// angle
	//----------------------------------------
	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			angle <= '0;
		end else begin
			case (key)
				`KEY_ROT_UP:   angle <= angle + 7'd1;
				`KEY_ROT_DOWN: angle <= angle - 7'd1;
				default: ;
			endcase
		end
	end

	//----------------------------------------
	// fire latch and phase counter
	//----------------------------------------
	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			fire_latch <= 1'b0;
			phase <= '0;
		end else begin
			phase <= phase + 1'b1;
			// a granted frame always clears the latch,
			// a fire key seen in that same frame is dropped
			if (fire_go) begin
				fire_latch <= 1'b0;
			end else if (key == `KEY_FIRE) begin
				fire_latch <= 1'b1;
			end
		end
	end

endmodule
